// ==== filelist.f ====
+incdir+bench
logic/tcm_pkg.sv
logic/tcm_bank.sv
logic/itcm_arbiter.sv
logic/data_port_router.sv
logic/tcm_subsystem.sv
bench/tcm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tcm_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/tcm_tb_tasks.svh ====
/*
 * TCM testbench helpers
 * failure stop, compare tasks, bounded waits and the two port drivers
 */

task automatic fail_stop(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
endtask

task automatic check_rsp(input string name, input rsp_t got, input rsp_t exp);
    if (got !== exp) begin
        fail_stop($sformatf("error: %s rdata %h code %h, expected rdata %h code %h",
                            name, got.rdata, got.code, exp.rdata, exp.code));
    end
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_stop($sformatf("error: %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_valid(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_stop($sformatf("error: %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
        fail_stop($sformatf("error: %s got %h expected %h cycles", name, got, exp));
    end
endtask

function automatic data_req_t make_req(addr_t a, logic write, data_t wdata, strb_t strb);
    data_req_t req;
    req.addr  = a;
    req.write = write;
    req.wdata = wdata;
    req.wstrb = strb;
    return req;
endfunction

// counts falling edges until the response strobe shows up
task automatic wait_data_rsp(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen) begin
        @(negedge clk);
        cycles++;
        seen = data_rsp_valid;
        if (!seen && cycles >= TIMEOUT) fail_stop("timeout waiting for a data response");
    end
endtask

task automatic wait_fetch_rsp(output int cycles);
    logic seen;
    seen   = 1'b0;
    cycles = 0;
    while (!seen) begin
        @(negedge clk);
        cycles++;
        seen = fetch_rsp_valid;
        if (!seen && cycles >= TIMEOUT) fail_stop("timeout waiting for a fetch response");
    end
endtask

// one data request, strobe held for exactly one cycle
task automatic data_access(input addr_t a, input logic write, input data_t wdata,
                           input strb_t strb, output rsp_t rsp);
    int n;
    @(posedge clk);
    data_req_valid <= 1'b1;
    data_req       <= make_req(a, write, wdata, strb);
    @(posedge clk);
    data_req_valid <= 1'b0;
    wait_data_rsp(n);
    check_latency("data_rsp latency", n, 1);
    rsp = data_rsp;
endtask

// fetch held until accepted
task automatic fetch_access(input addr_t a, output rsp_t rsp);
    logic ready_seen;
    int   waited;
    int   n;
    ready_seen = 1'b0;
    waited     = 0;
    @(posedge clk);
    fetch_valid    <= 1'b1;
    fetch_req.addr <= a;
    while (!ready_seen) begin
        @(negedge clk);
        ready_seen = fetch_ready;   // accepted at the coming edge
        waited++;
        if (!ready_seen && waited >= TIMEOUT) fail_stop("timeout waiting for fetch_ready");
        @(posedge clk);
    end
    fetch_valid <= 1'b0;
    wait_fetch_rsp(n);
    check_latency("fetch_rsp latency", n, 1);
    rsp = fetch_rsp;
endtask

// ==== bench/tcm_tb.sv ====
/*
 * TCM subsystem testbench
 * directed tests of the fetch and data ports against a reference memory per region
 */
`timescale 1ns/100ps
`default_nettype none

module tcm_tb
    import tcm_pkg::*;
();

    localparam addr_t ITCM_BASE = 32'h0000_0000;
    localparam addr_t DTCM_BASE = 32'h0001_0000;
    localparam int    ITCM_AW   = 10;
    localparam int    DTCM_AW   = 10;
    localparam int    TIMEOUT   = 20;   // cycles allowed per wait
    localparam int    PRELOAD   = 16;   // words written up front in each region

    logic       clk;
    logic       rst_n;
    logic       fetch_valid;
    fetch_req_t fetch_req;
    logic       fetch_ready;
    logic       fetch_rsp_valid;
    rsp_t       fetch_rsp;
    logic       data_req_valid;
    data_req_t  data_req;
    logic       data_rsp_valid;
    rsp_t       data_rsp;

    data_t itcm_model [int];   // keyed by word index inside the region
    data_t dtcm_model [int];

    tcm_subsystem uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_req       (fetch_req),
        .fetch_ready     (fetch_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp)
    );

    `include "tcm_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // region runs from its base over 4 bytes per word
    function automatic bit in_itcm(addr_t a);
        return (a >= ITCM_BASE) && (a < ITCM_BASE + (32'd4 << ITCM_AW));
    endfunction

    // only the strobed bytes of the old word are replaced
    function automatic data_t merge_bytes(data_t old_word, data_t wdata, strb_t strb);
        data_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) result[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return result;
    endfunction

    function automatic void model_write(addr_t a, data_t wdata, strb_t strb);
        int idx;
        if (in_itcm(a)) begin
            idx = int'(a[ITCM_AW+1:2]);
            itcm_model[idx] = merge_bytes(itcm_model.exists(idx) ? itcm_model[idx] : '0,
                                          wdata, strb);
        end else begin
            idx = int'(a[DTCM_AW+1:2]);
            dtcm_model[idx] = merge_bytes(dtcm_model.exists(idx) ? dtcm_model[idx] : '0,
                                          wdata, strb);
        end
    endfunction

    function automatic data_t model_read(addr_t a);
        if (in_itcm(a)) return itcm_model[int'(a[ITCM_AW+1:2])];
        return dtcm_model[int'(a[DTCM_AW+1:2])];
    endfunction

    function automatic rsp_t okay_rsp(data_t d);
        rsp_t r;
        r.rdata = d;
        r.code  = RSP_OKAY;
        return r;
    endfunction

    function automatic rsp_t decerr_rsp();
        rsp_t r;
        r.rdata = '0;
        r.code  = RSP_DECERR;
        return r;
    endfunction

    function automatic strb_t rand_strb();
        data_t r;
        r = $urandom();
        return r[3:0];
    endfunction

    task automatic do_write(input addr_t a, input data_t wdata, input strb_t strb);
        rsp_t rsp;
        data_access(a, 1'b1, wdata, strb, rsp);
        check_rsp("data_rsp", rsp, okay_rsp('0));   // writes return zero
        model_write(a, wdata, strb);
    endtask

    task automatic do_read_check(input addr_t a);
        rsp_t rsp;
        data_access(a, 1'b0, '0, '0, rsp);
        check_rsp("data_rsp", rsp, okay_rsp(model_read(a)));
    endtask

    task automatic preload_words();
        for (int i = 0; i < PRELOAD; i++) begin
            do_write(ITCM_BASE + 4 * i, $urandom(), 4'hf);
            do_write(DTCM_BASE + 4 * i, $urandom(), 4'hf);
        end
    endtask

    task automatic test_dtcm_strobed_write();
        for (int i = 0; i < 8; i++) begin
            do_write(DTCM_BASE + 4 * i, $urandom(), rand_strb());
            do_read_check(DTCM_BASE + 4 * i);
        end
    endtask

    task automatic test_itcm_write_fetch();
        rsp_t rsp;
        for (int i = 4; i < 8; i++) begin
            do_write(ITCM_BASE + 4 * i, $urandom(), rand_strb());
            fetch_access(ITCM_BASE + 4 * i, rsp);
            check_rsp("fetch_rsp", rsp, okay_rsp(model_read(ITCM_BASE + 4 * i)));
        end
    endtask

    // fetch and data port hit the ITCM in the same cycle
    task automatic test_fetch_conflict();
        addr_t fa;
        addr_t da;
        int    n;
        fa = ITCM_BASE + 32'h8;
        da = ITCM_BASE + 32'h20;
        @(posedge clk);
        fetch_valid    <= 1'b1;
        fetch_req.addr <= fa;
        data_req_valid <= 1'b1;
        data_req       <= make_req(da, 1'b0, '0, '0);
        @(negedge clk);
        check_ready("fetch_ready", fetch_ready, 1'b0);
        @(posedge clk);
        data_req_valid <= 1'b0;
        @(negedge clk);
        check_valid("data_rsp_valid", data_rsp_valid, 1'b1);
        check_rsp("data_rsp", data_rsp, okay_rsp(model_read(da)));
        check_ready("fetch_ready", fetch_ready, 1'b1);
        check_valid("fetch_rsp_valid", fetch_rsp_valid, 1'b0);
        @(posedge clk);
        fetch_valid <= 1'b0;   // accepted at this edge
        wait_fetch_rsp(n);
        check_latency("fetch_rsp latency", n, 1);
        check_rsp("fetch_rsp", fetch_rsp, okay_rsp(model_read(fa)));
    endtask

    task automatic test_unmapped();
        rsp_t rsp;
        data_access(32'h0000_2000, 1'b0, '0, '0, rsp);
        check_rsp("data_rsp", rsp, decerr_rsp());
        data_access(32'h0000_1010, 1'b1, $urandom(), 4'hf, rsp);   // aliases itcm word 4
        check_rsp("data_rsp", rsp, decerr_rsp());
        data_access(32'h0001_1020, 1'b1, $urandom(), 4'hf, rsp);   // aliases dtcm word 8
        check_rsp("data_rsp", rsp, decerr_rsp());
        fetch_access(32'h0000_1004, rsp);
        check_rsp("fetch_rsp", rsp, decerr_rsp());
        fetch_access(DTCM_BASE, rsp);   // fetch never reaches the DTCM
        check_rsp("fetch_rsp", rsp, decerr_rsp());
        do_read_check(ITCM_BASE + 32'h10);
        do_read_check(DTCM_BASE + 32'h20);
        fetch_access(ITCM_BASE + 32'h10, rsp);
        check_rsp("fetch_rsp", rsp, okay_rsp(model_read(ITCM_BASE + 32'h10)));
    endtask

    // one read per cycle, ITCM and DTCM in turn
    task automatic test_back_to_back();
        addr_t addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = (i % 2 == 0) ? ITCM_BASE + 4 * i : DTCM_BASE + 4 * i;
        end
        for (int i = 0; i <= 8; i++) begin
            @(posedge clk);
            if (i < 8) begin
                data_req_valid <= 1'b1;
                data_req       <= make_req(addrs[i], 1'b0, '0, '0);
            end else begin
                data_req_valid <= 1'b0;
            end
            @(negedge clk);
            if (i == 0) begin
                check_valid("data_rsp_valid", data_rsp_valid, 1'b0);
            end else begin
                check_valid("data_rsp_valid", data_rsp_valid, 1'b1);
                check_rsp("data_rsp", data_rsp, okay_rsp(model_read(addrs[i-1])));
            end
        end
    endtask

    initial begin
        void'($urandom(32'hadc7_9a82));
        rst_n          <= 1'b0;
        fetch_valid    <= 1'b0;
        fetch_req      <= '0;
        data_req_valid <= 1'b0;
        data_req       <= '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_valid("fetch_rsp_valid", fetch_rsp_valid, 1'b0);
        check_valid("data_rsp_valid", data_rsp_valid, 1'b0);
        check_ready("fetch_ready", fetch_ready, 1'b1);
        preload_words();
        test_dtcm_strobed_write();
        test_itcm_write_fetch();
        test_fetch_conflict();
        test_unmapped();
        test_back_to_back();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/tcm_subsystem.sv ====
/*
 * TCM subsystem top level
 * fetch port and data port over one ITCM and one DTCM bank
 */
`timescale 1ns/100ps
`default_nettype none

module tcm_subsystem
    import tcm_pkg::*;
#(
    parameter addr_t ITCM_BASE = 32'h0000_0000,
    parameter addr_t DTCM_BASE = 32'h0001_0000,
    parameter int    ITCM_AW   = 10,   // word address bits
    parameter int    DTCM_AW   = 10
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // fetch port, read only, ITCM only
    input  wire logic       fetch_valid,
    input  wire fetch_req_t fetch_req,
    output logic            fetch_ready,
    output logic            fetch_rsp_valid,
    output rsp_t            fetch_rsp,
    // data port, single-cycle strobe
    input  wire logic       data_req_valid,
    input  wire data_req_t  data_req,
    output logic            data_rsp_valid,
    output rsp_t            data_rsp
);

    logic      itcm_req_valid;
    bank_cmd_t itcm_req;
    logic      itcm_rsp_valid;
    rsp_t      itcm_rsp;
    logic      itcm_bank_valid;
    bank_cmd_t itcm_bank_cmd;
    data_t     itcm_rdata;
    logic      dtcm_valid;
    bank_cmd_t dtcm_cmd;
    data_t     dtcm_rdata;

    data_port_router #(
        .ITCM_BASE (ITCM_BASE),
        .ITCM_AW   (ITCM_AW),
        .DTCM_BASE (DTCM_BASE),
        .DTCM_AW   (DTCM_AW)
    ) router (
        .clk            (clk),
        .rst_n          (rst_n),
        .data_req_valid (data_req_valid),
        .data_req       (data_req),
        .data_rsp_valid (data_rsp_valid),
        .data_rsp       (data_rsp),
        .itcm_req_valid (itcm_req_valid),
        .itcm_req       (itcm_req),
        .itcm_rsp_valid (itcm_rsp_valid),
        .itcm_rsp       (itcm_rsp),
        .dtcm_valid     (dtcm_valid),
        .dtcm_cmd       (dtcm_cmd),
        .dtcm_rdata     (dtcm_rdata)
    );

    itcm_arbiter #(
        .ITCM_BASE (ITCM_BASE),
        .ITCM_AW   (ITCM_AW)
    ) arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_valid     (fetch_valid),
        .fetch_req       (fetch_req),
        .fetch_ready     (fetch_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .itcm_req_valid  (itcm_req_valid),
        .itcm_req        (itcm_req),
        .itcm_rsp_valid  (itcm_rsp_valid),
        .itcm_rsp        (itcm_rsp),
        .bank_valid      (itcm_bank_valid),
        .bank_cmd        (itcm_bank_cmd),
        .bank_rdata      (itcm_rdata)
    );

    tcm_bank #(.WORD_AW(ITCM_AW)) itcm_bank (
        .clk       (clk),
        .cmd_valid (itcm_bank_valid),
        .cmd       (itcm_bank_cmd),
        .rdata     (itcm_rdata)
    );

    tcm_bank #(.WORD_AW(DTCM_AW)) dtcm_bank (
        .clk       (clk),
        .cmd_valid (dtcm_valid),
        .cmd       (dtcm_cmd),
        .rdata     (dtcm_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/data_port_router.sv ====
/*
 * Data port router
 * decodes each data request to ITCM, DTCM or unmapped, issues the bank
 * command and picks the response from a registered target tag
 */
`timescale 1ns/100ps
`default_nettype none

module data_port_router
    import tcm_pkg::*;
#(
    parameter addr_t ITCM_BASE = 32'h0000_0000,
    parameter int    ITCM_AW   = 10,
    parameter addr_t DTCM_BASE = 32'h0001_0000,
    parameter int    DTCM_AW   = 10
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    // data port
    input  wire logic      data_req_valid,
    input  wire data_req_t data_req,
    output logic           data_rsp_valid,
    output rsp_t           data_rsp,
    // toward the ITCM arbiter
    output logic           itcm_req_valid,
    output bank_cmd_t      itcm_req,
    input  wire logic      itcm_rsp_valid,
    input  wire rsp_t      itcm_rsp,
    // DTCM bank
    output logic           dtcm_valid,
    output bank_cmd_t      dtcm_cmd,
    input  wire data_t     dtcm_rdata
);

    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_ITCM,
        TGT_DTCM,
        TGT_ERR
    } target_t;

    logic      itcm_hit;
    logic      dtcm_hit;
    bank_cmd_t cmd;
    target_t   tgt_d;
    target_t   tgt_q;
    logic      rd_q;   // outstanding request was a read

    assign itcm_hit = data_req.addr[31:ITCM_AW+2] == ITCM_BASE[31:ITCM_AW+2];
    assign dtcm_hit = data_req.addr[31:DTCM_AW+2] == DTCM_BASE[31:DTCM_AW+2];

    always_comb begin
        cmd.widx  = data_req.addr[31:2];   // byte address to word index
        cmd.write = data_req.write;
        cmd.wdata = data_req.wdata;
        cmd.wstrb = data_req.wstrb;
    end

    assign itcm_req_valid = data_req_valid && itcm_hit;
    assign itcm_req       = cmd;
    assign dtcm_valid     = data_req_valid && !itcm_hit && dtcm_hit;
    assign dtcm_cmd       = cmd;

    always_comb begin
        if (!data_req_valid)  tgt_d = TGT_NONE;
        else if (itcm_hit)    tgt_d = TGT_ITCM;
        else if (dtcm_hit)    tgt_d = TGT_DTCM;
        else                  tgt_d = TGT_ERR;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tgt_q <= TGT_NONE;
            rd_q  <= 1'b0;
        end else begin
            tgt_q <= tgt_d;
            rd_q  <= data_req_valid && !data_req.write;
        end
    end

    always_comb begin
        data_rsp_valid = 1'b0;
        data_rsp       = '0;
        case (tgt_q)
            TGT_ITCM: begin
                data_rsp_valid = itcm_rsp_valid;   // arbiter answers one cycle on
                data_rsp.rdata = rd_q ? itcm_rsp.rdata : '0;
                data_rsp.code  = itcm_rsp.code;
            end
            TGT_DTCM: begin
                data_rsp_valid = 1'b1;
                data_rsp.rdata = rd_q ? dtcm_rdata : '0;
                data_rsp.code  = RSP_OKAY;
            end
            TGT_ERR: begin
                data_rsp_valid = 1'b1;
                data_rsp.code  = RSP_DECERR;   // no bank was touched
            end
            default: begin
                data_rsp_valid = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/itcm_arbiter.sv ====
/*
 * ITCM arbiter
 * decodes fetch requests, grants the ITCM bank to the data port first and
 * steers the returning read word to fetch or data with registered owner tags
 */
`timescale 1ns/100ps
`default_nettype none

module itcm_arbiter
    import tcm_pkg::*;
#(
    parameter addr_t ITCM_BASE = 32'h0000_0000,
    parameter int    ITCM_AW   = 10
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    // fetch port
    input  wire logic       fetch_valid,
    input  wire fetch_req_t fetch_req,
    output logic            fetch_ready,
    output logic            fetch_rsp_valid,
    output rsp_t            fetch_rsp,
    // data port side, from the router
    input  wire logic       itcm_req_valid,
    input  wire bank_cmd_t  itcm_req,
    output logic            itcm_rsp_valid,
    output rsp_t            itcm_rsp,
    // ITCM bank
    output logic            bank_valid,
    output bank_cmd_t       bank_cmd,
    input  wire data_t      bank_rdata
);

    logic      fetch_hit;
    logic      fetch_fire;
    bank_cmd_t fetch_cmd;

    // owner tags for the word coming back next cycle
    logic      fetch_pend_q;
    logic      fetch_err_q;   // unmapped fetch, bank not touched
    logic      data_pend_q;

    assign fetch_hit = fetch_req.addr[31:ITCM_AW+2] == ITCM_BASE[31:ITCM_AW+2];

    // data port always wins, fetch waits out the conflict cycle
    assign fetch_ready = !itcm_req_valid;
    assign fetch_fire  = fetch_valid && fetch_ready;

    always_comb begin
        fetch_cmd       = '0;
        fetch_cmd.widx  = fetch_req.addr[31:2];
        fetch_cmd.write = 1'b0;   // fetch only reads
    end

    assign bank_valid = itcm_req_valid || (fetch_fire && fetch_hit);
    assign bank_cmd   = itcm_req_valid ? itcm_req : fetch_cmd;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pend_q <= 1'b0;
            fetch_err_q  <= 1'b0;
            data_pend_q  <= 1'b0;
        end else begin
            fetch_pend_q <= fetch_fire;
            fetch_err_q  <= fetch_fire && !fetch_hit;
            data_pend_q  <= itcm_req_valid;
        end
    end

    assign fetch_rsp_valid = fetch_pend_q;
    assign fetch_rsp.rdata = fetch_err_q ? '0 : bank_rdata;
    assign fetch_rsp.code  = fetch_err_q ? RSP_DECERR : RSP_OKAY;

    // write data zeroing is left to the router, it knows read from write
    assign itcm_rsp_valid = data_pend_q;
    assign itcm_rsp.rdata = bank_rdata;
    assign itcm_rsp.code  = RSP_OKAY;

endmodule

`default_nettype wire

// ==== logic/tcm_bank.sv ====
/*
 * TCM bank
 * single-port word memory, byte-strobed write, one-cycle registered read
 */
`timescale 1ns/100ps
`default_nettype none

module tcm_bank
    import tcm_pkg::*;
#(
    parameter int WORD_AW = 10   // word address bits
) (
    input  wire logic      clk,
    input  wire logic      cmd_valid,
    input  wire bank_cmd_t cmd,
    output data_t          rdata
);

    localparam int DEPTH = 2 ** WORD_AW;

    data_t                mem [DEPTH];
    logic [WORD_AW-1:0]   idx;

    assign idx = cmd.widx[WORD_AW-1:0];   // upper index bits already decoded away

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            if (cmd.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (cmd.wstrb[b]) begin
                        mem[idx][b*8 +: 8] <= cmd.wdata[b*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[idx];   // valid next cycle
            end
        end
    end

    // rdata keeps the last read word otherwise

endmodule

`default_nettype wire

// ==== logic/tcm_pkg.sv ====
/*
 * TCM subsystem shared types
 * address, data, strobe and response codes plus the request, bank command
 * and response structs used between the ports, the arbiter and the banks
 */
`default_nettype none

package tcm_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] data_t;   // one memory word
    typedef logic [3:0]  strb_t;   // one enable per byte of data_t
    typedef logic [29:0] widx_t;   // word index, byte address without [1:0]

    // same encoding as the AXI resp field
    typedef enum logic [1:0] {
        RSP_OKAY   = 2'b00,
        RSP_DECERR = 2'b11
    } rsp_code_t;

    typedef struct packed {
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        addr_t addr;
        logic  write;   // 1 = write, 0 = read
        data_t wdata;
        strb_t wstrb;
    } data_req_t;

    // what one bank sees, banks use only the low bits of widx
    typedef struct packed {
        widx_t widx;
        logic  write;
        data_t wdata;
        strb_t wstrb;
    } bank_cmd_t;

    typedef struct packed {
        data_t     rdata;
        rsp_code_t code;
    } rsp_t;

endpackage

`default_nettype wire
